/* verilog/frv_uop_pkg.sv */
`default_nettype none

package frv_uop_pkg;

    // One-hot functional unit field ------
    localparam int P_FU_ALU = 0;          // Integer ALU
    localparam int P_FU_MUL = 1;          // Multiply / divide
    localparam int P_FU_LSU = 2;          // Load / store
    localparam int P_FU_CFU = 3;          // Control flow
    localparam int P_FU_CSR = 4;          // CSR access

    // Micro-op flag bits (LSU and CSR units)
    localparam int LSU_LOAD  = 0;         // Load, result goes to rd
    localparam int CSR_READ  = 0;         // Old CSR value goes to rd
    localparam int CSR_WRITE = 1;         // Replace
    localparam int CSR_SET   = 2;         // OR into CSR
    localparam int CSR_CLEAR = 3;         // AND-NOT into CSR

    // Control-flow codes, CFU only
    typedef enum logic [4:0] {
        CFU_TAKEN    = 5'd1,              // Taken conditional branch
        CFU_JALI     = 5'd2,              // JAL, links s3_pc
        CFU_JALR     = 5'd3,              // JALR, links s3_pc
        CFU_EBREAK   = 5'd4,
        CFU_ECALL    = 5'd5,
        CFU_MRET     = 5'd6,              // Return to mepc
        CFU_NOTTAKEN = 5'd7               // Branch falls through, no request
    } cfu_op_e;

    // Same 5-bit word, two views picked by the functional unit
    typedef union packed {
        logic [4:0] flags;                // LSU / CSR flag view
        cfu_op_e    cfu;                  // CFU code view
    } frv_uop_u;

endpackage

`default_nettype wire

/* verilog/frv_csr_pkg.sv */
`default_nettype none

package frv_csr_pkg;

    // Top data bit, RV32 only
    localparam int XL = 31;

    // Machine-mode CSR addresses ---------
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;   // Trap return address
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;   // Bit 31 marks external trap
    localparam logic [11:0] CSR_MTVAL    = 12'h343;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;   // Trap vector, direct mode

    // Synchronous trap causes
    localparam logic [5:0] TRAP_BREAKPT = 6'd3;       // EBREAK
    localparam logic [5:0] TRAP_ECALLM  = 6'd11;      // ECALL from M-mode

endpackage

`default_nettype wire

/* verilog/frv_pipeline_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

module frv_pipeline_writeback
    import frv_csr_pkg::*;
    import frv_uop_pkg::*;
(
    input  logic        g_clk,
    input  logic        g_resetn,

    input  logic [XL:0] s3_pc,            // Next PC, link value for JAL[R]
    input  logic [4:0]  s4_rd,
    input  logic [XL:0] s4_opr_a,         // Result, jump target or trap cause
    input  logic [XL:0] s4_opr_b,         // CSR address in low 12 bits
    input  logic [XL:0] s4_pc,
    input  frv_uop_u    s4_uop,
    input  logic [4:0]  s4_fu,            // One-hot
    input  logic        s4_trap,          // External trap on this instruction
    input  logic [1:0]  s4_size,
    input  logic [31:0] s4_instr,
    input  logic        s4_p_valid,
    output logic        s4_p_busy,

    output logic [4:0]  fwd_s4_rd,
    output logic [XL:0] fwd_s4_wdata,
    output logic        fwd_s4_csr,

    output logic        gpr_wen,
    output logic [4:0]  gpr_rd,
    output logic [XL:0] gpr_wdata,

    output logic        trap_cpu,         // ECALL / EBREAK taken
    output logic        trap_int,         // External trap taken
    output logic [5:0]  trap_cause,
    output logic [XL:0] trap_mtval,
    output logic [XL:0] trap_pc,
    output logic        exec_mret,

    input  logic [XL:0] csr_mepc,
    input  logic [XL:0] csr_mtvec,

    output logic        csr_en,
    output logic        csr_wr,
    output logic        csr_wr_set,
    output logic        csr_wr_clr,
    output logic [11:0] csr_addr,
    output logic [XL:0] csr_wdata,
    input  logic [XL:0] csr_rdata,        // Old value, combinational

    output logic        cf_req,
    output logic [XL:0] cf_target,
    input  logic        cf_ack,

    output logic [XL:0] trs_pc,
    output logic [31:0] trs_instr,
    output logic        trs_valid
);

    logic pipe_progress;                  // Instruction accepted this cycle
    logic fu_alu, fu_mul, fu_lsu, fu_cfu, fu_csr;
    logic lsu_load, csr_read;
    logic cfu_taken, cfu_link, cfu_ebreak, cfu_ecall, cfu_mret;
    logic cfu_sys_trap;                   // ECALL or EBREAK
    logic cfu_need;                       // Needs a fetch redirect

    // Decode ------------------------------
    assign fu_alu = s4_fu[P_FU_ALU];
    assign fu_mul = s4_fu[P_FU_MUL];
    assign fu_lsu = s4_fu[P_FU_LSU];
    assign fu_cfu = s4_fu[P_FU_CFU];
    assign fu_csr = s4_fu[P_FU_CSR];

    assign lsu_load   = fu_lsu && s4_uop.flags[LSU_LOAD];
    assign csr_read   = fu_csr && s4_uop.flags[CSR_READ];

    assign cfu_taken  = fu_cfu && (s4_uop.cfu == CFU_TAKEN || s4_uop.cfu == CFU_JALI ||
                                   s4_uop.cfu == CFU_JALR);
    assign cfu_link   = fu_cfu && (s4_uop.cfu == CFU_JALI || s4_uop.cfu == CFU_JALR);
    assign cfu_ebreak = fu_cfu && s4_uop.cfu == CFU_EBREAK;
    assign cfu_ecall  = fu_cfu && s4_uop.cfu == CFU_ECALL;
    assign cfu_mret   = fu_cfu && s4_uop.cfu == CFU_MRET;

    assign cfu_sys_trap = cfu_ebreak || cfu_ecall;
    assign cfu_need     = s4_trap || cfu_taken || cfu_sys_trap || cfu_mret;

    // Control flow handshake ------------
    // Ack and acceptance share a cycle, so the request drops as the instruction leaves
    assign cf_req    = s4_p_valid && cfu_need;
    assign s4_p_busy = cf_req && !cf_ack; // Stall until fetch takes the redirect

    assign pipe_progress = s4_p_valid && !s4_p_busy;

    always_comb begin
        if (s4_trap || cfu_sys_trap) begin
            cf_target = csr_mtvec;        // Any trap goes to the vector
        end else if (cfu_mret) begin
            cf_target = csr_mepc;
        end else begin
            cf_target = s4_opr_a;         // Branch / jump target
        end
    end

    // CSR access --------------------------
    // Strobes only on the accepting edge, never alongside a trap
    assign csr_en     = pipe_progress && fu_csr && !s4_trap;
    assign csr_wr     = csr_en && s4_uop.flags[CSR_WRITE];
    assign csr_wr_set = csr_en && s4_uop.flags[CSR_SET];
    assign csr_wr_clr = csr_en && s4_uop.flags[CSR_CLEAR];
    assign csr_addr   = s4_opr_b[11:0];
    assign csr_wdata  = s4_opr_a;

    // GPR writeback -------------------------
    assign gpr_rd  = s4_rd;
    assign gpr_wen = pipe_progress && !s4_trap &&
                     (fu_alu || fu_mul || lsu_load || csr_read || cfu_link);

    always_comb begin
        if (csr_read) begin
            gpr_wdata = csr_rdata;        // Old CSR value
        end else if (cfu_link) begin
            gpr_wdata = s3_pc;            // Return address
        end else begin
            gpr_wdata = s4_opr_a;         // ALU, MUL, load
        end
    end

    assign fwd_s4_rd    = s4_rd;
    assign fwd_s4_wdata = gpr_wdata;
    assign fwd_s4_csr   = s4_p_valid && fu_csr;

    // Traps ------------------------------
    // External trap wins over ECALL / EBREAK on the same instruction
    assign trap_int   = pipe_progress && s4_trap;
    assign trap_cpu   = pipe_progress && cfu_sys_trap && !s4_trap;
    assign trap_cause = s4_trap    ? s4_opr_a[5:0] :
                        cfu_ebreak ? TRAP_BREAKPT  :
                                     TRAP_ECALLM;
    assign trap_mtval = '0;
    assign trap_pc    = s4_pc;
    assign exec_mret  = pipe_progress && cfu_mret && !s4_trap;

    // Trace
    assign trs_pc    = s4_pc;
    assign trs_instr = s4_instr;
    assign trs_valid = pipe_progress;

    // A stalled redirect is still in the stage on the next cycle
    a_busy_cfu: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s4_p_busy |=> s4_p_valid && (fu_cfu || s4_trap));

    // Request held with a fixed target until fetch acks
    a_cf_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cf_req && !cf_ack |=> cf_req && $stable(cf_target));

    // Upstream keeps the instruction steady while stalled
    a_s4_stable: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s4_p_valid && s4_p_busy |=>
            s4_p_valid && $stable({s4_pc, s4_instr, s4_size, s4_uop, s4_fu, s4_rd}));

endmodule

`default_nettype wire

/* verilog/frv_csr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module frv_csr_unit
    import frv_csr_pkg::*;
#(
    parameter logic [31:0] MTVEC_RESET = 32'h0000_0000
) (
    input  logic        g_clk,
    input  logic        g_resetn,

    input  logic        csr_en,           // Access this cycle
    input  logic        csr_wr,           // Replace
    input  logic        csr_wr_set,       // OR in
    input  logic        csr_wr_clr,       // AND-NOT in
    input  logic [11:0] csr_addr,
    input  logic [XL:0] csr_wdata,
    output logic [XL:0] csr_rdata,        // Value before this cycle's update

    input  logic        trap_cpu,
    input  logic        trap_int,
    input  logic [5:0]  trap_cause,
    input  logic [XL:0] trap_mtval,
    input  logic [XL:0] trap_pc,
    input  logic        exec_mret,        // No state change in M-only core

    output logic [XL:0] csr_mepc,
    output logic [XL:0] csr_mtvec
);

    logic [XL:0] mtvec, mepc, mcause, mtval, mscratch;
    logic        trap_any;
    logic        csr_we;
    logic [XL:0] csr_wval;                // Value after read-modify-write

    // Read side ------------------------------
    always_comb begin
        case (csr_addr)
            CSR_MSCRATCH: csr_rdata = mscratch;
            CSR_MEPC:     csr_rdata = mepc;
            CSR_MCAUSE:   csr_rdata = mcause;
            CSR_MTVAL:    csr_rdata = mtval;
            CSR_MTVEC:    csr_rdata = mtvec;
            default:      csr_rdata = '0;   // Unimplemented reads as zero
        endcase
    end

    always_comb begin
        if (csr_wr_set) begin
            csr_wval = csr_rdata | csr_wdata;
        end else if (csr_wr_clr) begin
            csr_wval = csr_rdata & ~csr_wdata;
        end else begin
            csr_wval = csr_wdata;
        end
    end

    assign trap_any = trap_cpu || trap_int;
    assign csr_we   = csr_en && (csr_wr || csr_wr_set || csr_wr_clr);

    // Update side ------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mtvec    <= {MTVEC_RESET[XL:2], 2'b00};
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            mscratch <= '0;
        end else if (trap_any) begin  // Trap beats a CSR write
            mepc   <= {trap_pc[XL:2], 2'b00};
            mcause <= {trap_int, {(XL - 6){1'b0}}, trap_cause};
            mtval  <= trap_mtval;
        end else if (csr_we) begin
            case (csr_addr)
                CSR_MSCRATCH: mscratch <= csr_wval;
                CSR_MEPC:     mepc     <= {csr_wval[XL:2], 2'b00};
                CSR_MCAUSE:   mcause   <= csr_wval;
                CSR_MTVAL:    mtval    <= csr_wval;
                CSR_MTVEC:    mtvec    <= {csr_wval[XL:2], 2'b00};
                default:      ;         // Writes to unknown CSRs dropped
            endcase
        end
    end

    assign csr_mepc  = mepc;
    assign csr_mtvec = mtvec;

    // One read-modify-write kind per access
    a_set_clr: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(csr_wr_set && csr_wr_clr));

    // Writeback never mixes a trap with a CSR access
    a_trap_csr: assert property (@(posedge g_clk) disable iff (!g_resetn)
        !(trap_any && csr_en));

    // MRET is exclusive with trap entry and CSR access
    a_mret_solo: assert property (@(posedge g_clk) disable iff (!g_resetn)
        exec_mret |-> !(trap_any || csr_en));

endmodule

`default_nettype wire

/* verilog/frv_gpr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module frv_gpr_file
    import frv_csr_pkg::*;
(
    input  logic        g_clk,
    input  logic        g_resetn,

    input  logic        gpr_wen,
    input  logic [4:0]  gpr_rd,
    input  logic [XL:0] gpr_wdata,

    input  logic [4:0]  rs1_addr,         // Decode read port
    output logic [XL:0] rs1_data
);

    logic [XL:0] regs [1:31];             // x0 not stored

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (gpr_wen && gpr_rd != 5'd0) begin
            regs[gpr_rd] <= gpr_wdata;    // Writes to x0 dropped
        end
    end

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];

    // Writeback must never commit X into the file
    a_wdata_known: assert property (@(posedge g_clk) disable iff (!g_resetn)
        gpr_wen |-> !$isunknown(gpr_wdata));

endmodule

`default_nettype wire

/* verilog/frv_core_backend.sv */
`timescale 1ns/1ps
`default_nettype none

module frv_core_backend
    import frv_csr_pkg::*;
#(
    parameter logic [31:0] MTVEC_RESET = 32'h0000_0000
) (
    input  logic        g_clk,
    input  logic        g_resetn,

    input  logic [XL:0] s3_pc,
    input  logic [4:0]  s4_rd,
    input  logic [XL:0] s4_opr_a,
    input  logic [XL:0] s4_opr_b,
    input  logic [XL:0] s4_pc,
    input  logic [4:0]  s4_uop,           // Raw micro-op word
    input  logic [4:0]  s4_fu,
    input  logic        s4_trap,
    input  logic [1:0]  s4_size,
    input  logic [31:0] s4_instr,
    input  logic        s4_p_valid,
    output logic        s4_p_busy,

    output logic        cf_req,
    output logic [XL:0] cf_target,
    input  logic        cf_ack,

    input  logic [4:0]  rs1_addr,
    output logic [XL:0] rs1_data,

    output logic [4:0]  fwd_s4_rd,
    output logic [XL:0] fwd_s4_wdata,
    output logic        fwd_s4_csr,

    output logic [XL:0] trs_pc,
    output logic [31:0] trs_instr,
    output logic        trs_valid
);

    // Writeback to register file
    logic        gpr_wen;
    logic [4:0]  gpr_rd;
    logic [XL:0] gpr_wdata;

    // Writeback to CSR unit ---------------
    logic        csr_en, csr_wr, csr_wr_set, csr_wr_clr;
    logic [11:0] csr_addr;
    logic [XL:0] csr_wdata, csr_rdata;
    logic        trap_cpu, trap_int, exec_mret;
    logic [5:0]  trap_cause;
    logic [XL:0] trap_mtval, trap_pc;
    logic [XL:0] csr_mepc, csr_mtvec;

    frv_pipeline_writeback u_writeback (.*);

    frv_csr_unit #(
        .MTVEC_RESET (MTVEC_RESET)
    ) u_csr (.*);

    frv_gpr_file u_gpr (.*);

endmodule

`default_nettype wire

/* dv/frv_backend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module frv_backend_tb
    import frv_csr_pkg::*;
    import frv_uop_pkg::*;
();

    localparam logic [31:0] MTVEC_RESET    = 32'h0000_0100;
    localparam int          NUM_INSTR      = 1200;             // Bound over all phases
    localparam int          TIMEOUT_CYCLES = NUM_INSTR * 20;

    logic        g_clk, g_resetn;
    logic [31:0] s3_pc, s4_opr_a, s4_opr_b, s4_pc, s4_instr;
    logic [4:0]  s4_rd, s4_uop, s4_fu, rs1_addr;
    logic        s4_trap, s4_p_valid, cf_ack;
    logic [1:0]  s4_size;
    logic        s4_p_busy, cf_req, fwd_s4_csr, trs_valid;
    logic [31:0] cf_target, rs1_data, fwd_s4_wdata, trs_pc, trs_instr;
    logic [4:0]  fwd_s4_rd;

    integer      seed = 70343;
    int          cycle_count = 0;
    int          error_count = 0;

    // Reference model ------------------------
    logic [31:0] m_gpr [0:31];
    logic [31:0] m_mtvec, m_mepc, m_mcause, m_mtval, m_mscratch;
    logic [11:0] csr_list [0:4];

    frv_core_backend #(
        .MTVEC_RESET (MTVEC_RESET)
    ) uut (.*);

    initial begin
        g_clk = 1'b0;
        forever #10 g_clk = ~g_clk;                              // 20 ns period
    end

    always @(posedge g_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("error: %s = %h, expected %h", name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [31:0] csr_model_read(input logic [11:0] addr);
        case (addr)
            CSR_MSCRATCH: return m_mscratch;
            CSR_MEPC:     return m_mepc;
            CSR_MCAUSE:   return m_mcause;
            CSR_MTVAL:    return m_mtval;
            CSR_MTVEC:    return m_mtvec;
            default:      return 32'h0;                          // Unknown reads zero
        endcase
    endfunction

    task automatic csr_model_write(input logic [11:0] addr, input logic [31:0] val);
        case (addr)
            CSR_MSCRATCH: m_mscratch = val;
            CSR_MEPC:     m_mepc     = val & ~32'h3;             // Word aligned
            CSR_MCAUSE:   m_mcause   = val;
            CSR_MTVAL:    m_mtval    = val;
            CSR_MTVEC:    m_mtvec    = val & ~32'h3;
            default:      ;
        endcase
    endtask

    // Drive one instruction and hold it until accepted
    task automatic issue(input logic [4:0] fu, input logic [4:0] uop, input logic [4:0] rd,
                         input logic [31:0] opr_a, input logic [31:0] opr_b,
                         input logic trap);
        logic        is_cfu, sys_trap, link, need, accepted, wen;
        logic        exp_req, exp_busy;
        logic [31:0] target, wdata, old_csr, pc, instr, rw;
        pc       = rand_word() & ~32'h3;
        instr    = rand_word();
        is_cfu   = fu[P_FU_CFU];
        sys_trap = is_cfu && (uop == CFU_ECALL || uop == CFU_EBREAK);
        link     = is_cfu && (uop == CFU_JALI || uop == CFU_JALR);
        need     = trap || sys_trap || (is_cfu && (link || uop == CFU_TAKEN ||
                                                   uop == CFU_MRET));
        old_csr  = csr_model_read(opr_b[11:0]);
        if (trap || sys_trap) begin
            target = m_mtvec;                                    // Trap vector
        end else if (is_cfu && uop == CFU_MRET) begin
            target = m_mepc;
        end else begin
            target = opr_a;
        end
        wen   = 1'b0;
        wdata = opr_a;
        if (!trap) begin
            if (fu[P_FU_ALU] || fu[P_FU_MUL] || (fu[P_FU_LSU] && uop[LSU_LOAD])) begin
                wen = 1'b1;
            end else if (fu[P_FU_CSR] && uop[CSR_READ]) begin
                wen   = 1'b1;
                wdata = old_csr;                                 // Old value to rd
            end else if (link) begin
                wen   = 1'b1;
                wdata = pc + 32'd4;                              // Link is s3_pc
            end
        end
        s4_fu      = fu;
        s4_uop     = uop;
        s4_rd      = rd;
        s4_opr_a   = opr_a;
        s4_opr_b   = opr_b;
        s4_pc      = pc;
        s4_instr   = instr;
        s3_pc      = pc + 32'd4;
        s4_trap    = trap;
        s4_size    = instr[13:12];
        s4_p_valid = 1'b1;
        accepted   = 1'b0;
        while (!accepted) begin
            rw       = rand_word();
            cf_ack   = rw[0];                                    // 50% ack per cycle
            rs1_addr = rw[9:5];
            #5;
            exp_req  = need;
            exp_busy = exp_req && !cf_ack;
            compare_value("cf_req", cf_req, exp_req);
            if (exp_req) begin
                compare_value("cf_target", cf_target, target);
            end
            compare_value("s4_p_busy", s4_p_busy, exp_busy);
            compare_value("trs_valid", trs_valid, !exp_busy);    // No trace while stalled
            compare_value("fwd_s4_csr", fwd_s4_csr, fu[P_FU_CSR]);
            compare_value("rs1_data", rs1_data, m_gpr[rs1_addr]); // Nothing written yet
            if (!exp_busy) begin
                compare_value("trs_pc", trs_pc, pc);
                compare_value("trs_instr", trs_instr, instr);
                compare_value("fwd_s4_rd", fwd_s4_rd, rd);
                if (wen) begin
                    compare_value("fwd_s4_wdata", fwd_s4_wdata, wdata);
                end
            end
            accepted = !exp_busy;
            @(negedge g_clk);
        end
        s4_p_valid = 1'b0;
        // Commit into the model ---------------
        if (wen && rd != 5'd0) begin
            m_gpr[rd] = wdata;
        end
        if (fu[P_FU_CSR] && !trap) begin
            if (uop[CSR_WRITE]) begin
                csr_model_write(opr_b[11:0], opr_a);
            end else if (uop[CSR_SET]) begin
                csr_model_write(opr_b[11:0], old_csr | opr_a);
            end else if (uop[CSR_CLEAR]) begin
                csr_model_write(opr_b[11:0], old_csr & ~opr_a);
            end
        end
        if (trap || sys_trap) begin
            m_mepc  = pc;
            m_mtval = 32'h0;
            if (trap) begin
                m_mcause = {1'b1, 25'd0, opr_a[5:0]};            // External, cause from opr_a
            end else if (uop == CFU_EBREAK) begin
                m_mcause = {26'd0, TRAP_BREAKPT};
            end else begin
                m_mcause = {26'd0, TRAP_ECALLM};
            end
        end
    endtask

    task automatic idle_cycle();
        logic [31:0] rw;
        rw         = rand_word();
        s4_p_valid = 1'b0;
        cf_ack     = rw[0];
        rs1_addr   = rw[9:5];
        #5;
        compare_value("cf_req", cf_req, 1'b0);
        compare_value("s4_p_busy", s4_p_busy, 1'b0);
        compare_value("trs_valid", trs_valid, 1'b0);
        compare_value("fwd_s4_csr", fwd_s4_csr, 1'b0);
        compare_value("rs1_data", rs1_data, m_gpr[rs1_addr]);
        @(negedge g_clk);
    endtask

    task automatic maybe_idle();
        logic [31:0] rw;
        rw = rand_word();
        if (rw[1:0] == 2'd0) begin
            idle_cycle();
        end
    endtask

    task automatic sweep_gprs();
        for (int i = 0; i < 32; i++) begin
            rs1_addr = i[4:0];
            #5;
            compare_value("rs1_data", rs1_data, m_gpr[i]);
            @(negedge g_clk);
        end
    endtask

    // Instruction generators ---------------
    task automatic gpr_op();
        logic [31:0] rw;
        rw = rand_word();
        issue(5'd1 << (rw[1:0] % 3), rw[6:2], rw[11:7], rand_word(), rand_word(), 1'b0);
    endtask

    task automatic csr_op(input logic [2:0] kind, input logic [11:0] addr);
        logic [31:0] rw, opr_b;
        logic [4:0]  uop;
        rw          = rand_word();
        opr_b       = rand_word();
        opr_b[11:0] = addr;
        uop         = 5'd0;
        uop[CSR_READ] = rw[0];
        case (kind)
            3'd1:    uop[CSR_WRITE] = 1'b1;
            3'd2:    uop[CSR_SET]   = 1'b1;
            3'd3:    uop[CSR_CLEAR] = 1'b1;
            default: uop[CSR_READ]  = 1'b1;                      // Plain read
        endcase
        issue(5'd1 << P_FU_CSR, uop, rw[5:1], rand_word(), opr_b, 1'b0);
    endtask

    task automatic cf_op();
        logic [31:0] rw;
        logic [4:0]  uop;
        rw = rand_word();
        case (rw[1:0])
            2'd0:    uop = CFU_TAKEN;
            2'd1:    uop = CFU_JALI;
            2'd2:    uop = CFU_JALR;
            default: uop = CFU_NOTTAKEN;                         // Must not request
        endcase
        issue(5'd1 << P_FU_CFU, uop, rw[6:2], rand_word() & ~32'h3, rand_word(), 1'b0);
    endtask

    task automatic trap_op();
        logic [31:0] rw;
        rw = rand_word();
        case (rw[1:0])
            2'd0:    issue(5'd1 << P_FU_CFU, CFU_ECALL, rw[6:2], rand_word(), 32'h0, 1'b0);
            2'd1:    issue(5'd1 << P_FU_CFU, CFU_EBREAK, rw[6:2], rand_word(), 32'h0, 1'b0);
            default: issue(5'd1 << (rw[8:7] % 3), rw[13:9], rw[6:2] | 5'd1, rand_word(),
                           rand_word(), 1'b1);                   // rd set but never written
        endcase
        csr_op(3'd0, CSR_MEPC);
        csr_op(3'd0, CSR_MCAUSE);
    endtask

    initial begin
        logic [31:0] rw;
        g_resetn   = 1'b0;
        s3_pc      = 32'h0;
        s4_rd      = 5'd0;
        s4_opr_a   = 32'h0;
        s4_opr_b   = 32'h0;
        s4_pc      = 32'h0;
        s4_uop     = 5'd0;
        s4_fu      = 5'd0;
        s4_trap    = 1'b0;
        s4_size    = 2'd0;
        s4_instr   = 32'h0;
        s4_p_valid = 1'b0;
        cf_ack     = 1'b0;
        rs1_addr   = 5'd0;
        for (int i = 0; i < 32; i++) begin
            m_gpr[i] = 32'h0;
        end
        m_mtvec     = MTVEC_RESET;
        m_mepc      = 32'h0;
        m_mcause    = 32'h0;
        m_mtval     = 32'h0;
        m_mscratch  = 32'h0;
        csr_list[0] = CSR_MSCRATCH;
        csr_list[1] = CSR_MEPC;
        csr_list[2] = CSR_MCAUSE;
        csr_list[3] = CSR_MTVAL;
        csr_list[4] = CSR_MTVEC;
        repeat (8) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;
        idle_cycle();
        sweep_gprs();                                            // All zero out of reset
        for (int i = 0; i < 5; i++) begin
            csr_op(3'd0, csr_list[i]);                           // Reset CSR values
        end
        for (int i = 0; i < 300; i++) begin
            gpr_op();
            maybe_idle();
        end
        sweep_gprs();
        for (int i = 0; i < 200; i++) begin
            rw = rand_word();
            csr_op(rw[2:0] % 4, csr_list[rw[10:8] % 5]);
            maybe_idle();
        end
        sweep_gprs();
        for (int i = 0; i < 150; i++) begin
            cf_op();
            maybe_idle();
        end
        sweep_gprs();
        for (int i = 0; i < 100; i++) begin
            trap_op();
            maybe_idle();
        end
        for (int i = 0; i < 50; i++) begin
            csr_op(3'd1, CSR_MEPC);                              // Fresh return address
            issue(5'd1 << P_FU_CFU, CFU_MRET, 5'd0, rand_word(), rand_word(), 1'b0);
            maybe_idle();
        end
        sweep_gprs();
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
verilog/frv_uop_pkg.sv
verilog/frv_csr_pkg.sv
verilog/frv_pipeline_writeback.sv
verilog/frv_csr_unit.sv
verilog/frv_gpr_file.sv
verilog/frv_core_backend.sv
dv/frv_backend_tb.sv

/* Bender.yml */
package:
  name: frv_core_backend

sources:
  # Packages first, then the RTL from the leaves up to the top
  - files:
      - verilog/frv_uop_pkg.sv
      - verilog/frv_csr_pkg.sv
      - verilog/frv_pipeline_writeback.sv
      - verilog/frv_csr_unit.sv
      - verilog/frv_gpr_file.sv
      - verilog/frv_core_backend.sv

  # Simulation only
  - target: test
    files:
      - dv/frv_backend_tb.sv
